// File: hdl/cpuPkg.sv
// Shared definitions for the 16-bit pipelined core
// Widths and memory size
// Opcode and ALU operation encodings
// Decoded control and the four pipeline stage payloads
// Memory request used by fetch, data side and the memory
`default_nettype none

package cpuPkg;

    localparam int DataWidth    = 16;
    localparam int RegAddrWidth = 3;
    localparam int MemWords     = 256;
    localparam int MemAddrWidth = $clog2(MemWords);

    typedef logic [DataWidth-1:0]    wordT;
    typedef logic [RegAddrWidth-1:0] regAddrT;

    // Instruction bits 15:12
    typedef enum logic [3:0] {
        OpAdd  = 4'd0,
        OpSub  = 4'd1,
        OpAnd  = 4'd2,
        OpXor  = 4'd3,
        OpAddi = 4'd4,
        OpLbi  = 4'd5,
        OpLd   = 4'd6,
        OpSt   = 4'd7,
        OpBeqz = 4'd8,
        OpJ    = 4'd9,
        OpHalt = 4'd15
    } opcodeT;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluXor,
        AluPassB
    } aluOpT;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  halt;
        aluOpT aluOp;
        logic  useImm;     // Operand B from immediate
    } ctrlT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        logic    valid;
        ctrlT    ctrl;
        regAddrT dest;
        wordT    a;        // rs value
        wordT    b;        // rt, or rd for stores
        wordT    imm;
    } idExT;

    typedef struct packed {
        logic    valid;
        ctrlT    ctrl;
        regAddrT dest;
        wordT    aluResult;
        wordT    storeData;
    } exMemT;

    typedef struct packed {
        logic    valid;
        logic    halt;
        logic    regWrite;
        regAddrT dest;
        wordT    value;
    } memWbT;

    typedef struct packed {
        logic valid;
        logic write;
        wordT addr;       // Word address
        wordT wdata;
    } memReqT;

endpackage

`default_nettype wire

// File: hdl/pipeReg.sv
// Stage register between two pipeline stages
// Payload type is a parameter, hold keeps the entry, bubble clears it
`timescale 1ns/10ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = cpuPkg::ifIdT
) (
    input  wire logic    clk,
    input  wire logic    arstN,
    input  wire logic    hold,
    input  wire logic    bubble,
    input  wire payloadT d,
    output payloadT      q
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            q <= '0;
        end else if (hold) begin
            q <= q;            // Stalled stage keeps its entry
        end else if (bubble) begin
            q <= '0;           // All fields zero, so valid drops
        end else begin
            q <= d;
        end
    end

    // Stall and squash come from different sources in the top
    holdBubbleExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(hold && bubble));

endmodule

`default_nettype wire

// File: hdl/fetchUnit.sv
// Instruction fetch stage
// Program counter with redirect and stall handling
// Fetch request to the memory arbiter, stops once HALT is decoded
`timescale 1ns/10ps
`default_nettype none

module fetchUnit (
    input  wire logic         clk,
    input  wire logic         arstN,
    input  wire logic         fetchStall,
    input  wire logic         decodeStall,
    input  wire logic         redirect,
    input  wire cpuPkg::wordT redirectPc,
    input  wire logic         haltSeen,
    input  wire cpuPkg::wordT instr,
    output cpuPkg::memReqT    fetchReq,
    output cpuPkg::ifIdT      fetched
);
    import cpuPkg::*;

    wordT pc;
    logic granted;

    assign granted = fetchReq.valid && !fetchStall;   // Arbiter let the fetch through

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;                     // Taken branch or jump
        end else if (granted && !decodeStall) begin
            pc <= pc + wordT'(1);
        end
    end

    // Fetch is a read only, so no write data
    assign fetchReq = '{valid: !haltSeen, write: 1'b0, addr: pc, wdata: '0};

    // A word that lost arbitration is marked empty
    assign fetched = '{valid: granted, pc: pc, instr: instr};

endmodule

`default_nettype wire

// File: hdl/decodeUnit.sv
// Instruction decode stage
// Eight-entry register file with write-through from writeback
// Control decode and immediate sign extension
// Load-use and ALU interlock against ID/EX and EX/MEM
// BEQZ and J resolution, sticky halt and illegal-opcode flags
`timescale 1ns/10ps
`default_nettype none

module decodeUnit (
    input  wire logic          clk,
    input  wire logic          arstN,
    input  wire cpuPkg::ifIdT  stage,
    input  wire cpuPkg::idExT  idExDest,
    input  wire cpuPkg::exMemT exMemDest,
    input  wire cpuPkg::memWbT wb,
    output cpuPkg::idExT       issue,
    output logic               decodeStall,
    output logic               redirect,
    output cpuPkg::wordT       redirectPc,
    output logic               haltSeen,
    output logic               illegal
);
    import cpuPkg::*;

    wordT    regFile [0:(1<<RegAddrWidth)-1];
    opcodeT  opcode;
    regAddrT rd, rs, rt, srcB;
    wordT    imm6, imm9, imm12, immExt;
    wordT    regA, regB;
    ctrlT    ctrl;
    logic    useA, useB, known, isBeqz, isJump, haltNow;
    logic    haltFlag, illegalFlag;

    // Source is written by an older instruction still in flight
    function automatic logic busy(input regAddrT r);
        busy = (idExDest.valid && idExDest.ctrl.regWrite && idExDest.dest == r) ||
               (exMemDest.valid && exMemDest.ctrl.regWrite && exMemDest.dest == r);
    endfunction

    function automatic wordT readReg(input regAddrT r);
        if (wb.valid && wb.regWrite && wb.dest == r) begin
            readReg = wb.value;                  // Same-cycle writeback
        end else begin
            readReg = regFile[r];
        end
    endfunction

    assign opcode = opcodeT'(stage.instr[15:12]);
    assign rd     = stage.instr[11:9];
    assign rs     = stage.instr[8:6];
    assign rt     = stage.instr[5:3];
    assign imm6   = {{(DataWidth-6){stage.instr[5]}}, stage.instr[5:0]};
    assign imm9   = {{(DataWidth-9){stage.instr[8]}}, stage.instr[8:0]};
    assign imm12  = {{(DataWidth-12){stage.instr[11]}}, stage.instr[11:0]};

    always_comb begin
        ctrl   = '0;
        useA   = 1'b0;
        useB   = 1'b0;
        srcB   = rt;
        immExt = imm6;
        known  = 1'b1;
        isBeqz = 1'b0;
        isJump = 1'b0;
        case (opcode)
            OpAdd, OpSub, OpAnd, OpXor: begin
                ctrl.regWrite = 1'b1;
                useA = 1'b1;
                useB = 1'b1;
                case (opcode)
                    OpSub:   ctrl.aluOp = AluSub;
                    OpAnd:   ctrl.aluOp = AluAnd;
                    OpXor:   ctrl.aluOp = AluXor;
                    default: ctrl.aluOp = AluAdd;
                endcase
            end
            OpAddi: begin
                ctrl = '{regWrite: 1'b1, memRead: 1'b0, memWrite: 1'b0, halt: 1'b0,
                         aluOp: AluAdd, useImm: 1'b1};
                useA = 1'b1;
            end
            OpLbi: begin
                ctrl = '{regWrite: 1'b1, memRead: 1'b0, memWrite: 1'b0, halt: 1'b0,
                         aluOp: AluPassB, useImm: 1'b1};
                immExt = imm9;
            end
            OpLd: begin
                ctrl = '{regWrite: 1'b1, memRead: 1'b1, memWrite: 1'b0, halt: 1'b0,
                         aluOp: AluAdd, useImm: 1'b1};
                useA = 1'b1;
            end
            OpSt: begin
                ctrl = '{regWrite: 1'b0, memRead: 1'b0, memWrite: 1'b1, halt: 1'b0,
                         aluOp: AluAdd, useImm: 1'b1};
                useA = 1'b1;
                useB = 1'b1;
                srcB = rd;                        // Store data rides in B
            end
            OpBeqz: begin
                isBeqz = 1'b1;
                useA   = 1'b1;
            end
            OpJ: begin
                isJump = 1'b1;
                immExt = imm12;
            end
            OpHalt:  ctrl.halt = 1'b1;
            default: known = 1'b0;                // Runs as a no-op
        endcase
    end

    always_comb begin
        regA        = readReg(rs);
        regB        = readReg(srcB);
        decodeStall = stage.valid && ((useA && busy(rs)) || (useB && busy(srcB)));
    end

    assign redirect   = stage.valid && !decodeStall && (isJump || (isBeqz && regA == '0));
    assign redirectPc = stage.pc + wordT'(1) + immExt;

    assign haltNow  = stage.valid && opcode == OpHalt;
    assign haltSeen = haltFlag || haltNow;   // Blocks the fetch behind HALT at once
    assign illegal  = illegalFlag;

    assign issue = '{valid: stage.valid, ctrl: ctrl, dest: rd, a: regA, b: regB,
                     imm: immExt};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < (1 << RegAddrWidth); i++) begin
                regFile[i] <= '0;
            end
            haltFlag    <= 1'b0;
            illegalFlag <= 1'b0;
        end else begin
            if (wb.valid && wb.regWrite) begin
                regFile[wb.dest] <= wb.value;
            end
            if (haltNow) begin
                haltFlag <= 1'b1;
            end
            if (stage.valid && !known) begin
                illegalFlag <= 1'b1;              // Sticky
            end
        end
    end

    redirectNotStalled: assert property (@(posedge clk) disable iff (!arstN)
        redirect |-> !decodeStall);

    // The top squashes the slot behind a taken branch
    redirectSquashes: assert property (@(posedge clk) disable iff (!arstN)
        redirect |=> !stage.valid);

endmodule

`default_nettype wire

// File: hdl/executeUnit.sv
// Execute stage, purely combinational
// Operand select and ALU, also forms load and store addresses
`timescale 1ns/10ps
`default_nettype none

module executeUnit (
    input  wire cpuPkg::idExT op,
    output cpuPkg::exMemT     result
);
    import cpuPkg::*;

    wordT operandB;
    wordT aluOut;

    assign operandB = op.ctrl.useImm ? op.imm : op.b;

    always_comb begin
        case (op.ctrl.aluOp)
            AluAdd:   aluOut = op.a + operandB;   // Also address for LD and ST
            AluSub:   aluOut = op.a - operandB;
            AluAnd:   aluOut = op.a & operandB;
            AluXor:   aluOut = op.a ^ operandB;
            AluPassB: aluOut = operandB;          // LBI
            default:  aluOut = '0;
        endcase
    end

    assign result = '{valid: op.valid, ctrl: op.ctrl, dest: op.dest,
                      aluResult: aluOut, storeData: op.b};

endmodule

`default_nettype wire

// File: hdl/memArbiter.sv
// Arbiter for the single memory port
// Data access has priority, a losing fetch is stalled
`timescale 1ns/10ps
`default_nettype none

module memArbiter (
    input  wire cpuPkg::memReqT fetchReq,
    input  wire cpuPkg::memReqT dataReq,
    output cpuPkg::memReqT      memReq,
    input  wire cpuPkg::wordT   rdata,
    output cpuPkg::wordT        fetchData,
    output cpuPkg::wordT        dataRdata,
    output logic                fetchStall
);

    // Data side wins whenever it asks
    assign memReq     = dataReq.valid ? dataReq : fetchReq;
    assign fetchStall = fetchReq.valid && dataReq.valid;

    // Read data is the same word for both sides, only one is granted
    assign fetchData = rdata;
    assign dataRdata = rdata;

    always_comb begin
        fetchNeverWrites: assert final (!(memReq.write && !dataReq.valid))
            else $error("Memory write granted to the fetch side");
    end

endmodule

`default_nettype wire

// File: hdl/unifiedMemory.sv
// Unified instruction and data memory, 256 words
// Combinational read, write at the clock edge
`timescale 1ns/10ps
`default_nettype none

module unifiedMemory (
    input  wire logic           clk,
    input  wire cpuPkg::memReqT req,
    output cpuPkg::wordT        rdata
);
    import cpuPkg::*;

    wordT mem [0:MemWords-1];
    logic [MemAddrWidth-1:0] index;

    assign index = req.addr[MemAddrWidth-1:0];   // Upper address bits ignored
    assign rdata = mem[index];

    always_ff @(posedge clk) begin
        if (req.valid && req.write) begin
            mem[index] <= req.wdata;
        end
    end

endmodule

`default_nettype wire

// File: hdl/proc.sv
// Top level of the five-stage pipelined core
// Fetch, decode and execute units with four stage registers
// Memory stage via the arbiter onto the unified memory
// Writeback observation ports and the halted flag
`timescale 1ns/10ps
`default_nettype none

module proc (
    input  wire logic       clk,
    input  wire logic       arstN,
    output logic            err,
    output logic            halted,
    output logic            wbValid,
    output cpuPkg::regAddrT wbDest,
    output cpuPkg::wordT    wbData
);
    import cpuPkg::*;

    ifIdT   ifIdD, ifIdQ;
    idExT   idExD, idExQ;
    exMemT  exMemD, exMemQ;
    memWbT  memWbD, memWbQ;
    memReqT fetchReq, dataReq, memReq;
    wordT   memRdata, fetchData, dataRdata, redirectPc;
    logic   fetchStall, decodeStall, redirect, haltSeen, haltLatch;

    fetchUnit fetch (
        .clk(clk), .arstN(arstN),
        .fetchStall(fetchStall), .decodeStall(decodeStall),
        .redirect(redirect), .redirectPc(redirectPc), .haltSeen(haltSeen),
        .instr(fetchData), .fetchReq(fetchReq), .fetched(ifIdD)
    );

    // Held on interlock, squashed on redirect or a lost fetch
    pipeReg #(.payloadT(ifIdT)) ifId (
        .clk(clk), .arstN(arstN),
        .hold(decodeStall), .bubble(!decodeStall && (redirect || fetchStall)),
        .d(ifIdD), .q(ifIdQ)
    );

    decodeUnit decode (
        .clk(clk), .arstN(arstN),
        .stage(ifIdQ), .idExDest(idExQ), .exMemDest(exMemQ), .wb(memWbQ),
        .issue(idExD), .decodeStall(decodeStall),
        .redirect(redirect), .redirectPc(redirectPc),
        .haltSeen(haltSeen), .illegal(err)
    );

    pipeReg #(.payloadT(idExT)) idEx (
        .clk(clk), .arstN(arstN),
        .hold(1'b0), .bubble(decodeStall),       // Bubble behind a stalled decode
        .d(idExD), .q(idExQ)
    );

    executeUnit execute (.op(idExQ), .result(exMemD));

    pipeReg #(.payloadT(exMemT)) exMem (
        .clk(clk), .arstN(arstN), .hold(1'b0), .bubble(1'b0),
        .d(exMemD), .q(exMemQ)
    );

    // Memory stage
    assign dataReq = '{valid: exMemQ.valid && (exMemQ.ctrl.memRead || exMemQ.ctrl.memWrite),
                       write: exMemQ.ctrl.memWrite,
                       addr:  exMemQ.aluResult,
                       wdata: exMemQ.storeData};

    memArbiter arbiter (
        .fetchReq(fetchReq), .dataReq(dataReq), .memReq(memReq),
        .rdata(memRdata), .fetchData(fetchData), .dataRdata(dataRdata),
        .fetchStall(fetchStall)
    );

    unifiedMemory mainMem (.clk(clk), .req(memReq), .rdata(memRdata));

    assign memWbD = '{valid:    exMemQ.valid,
                      halt:     exMemQ.ctrl.halt,
                      regWrite: exMemQ.ctrl.regWrite,
                      dest:     exMemQ.dest,
                      value:    exMemQ.ctrl.memRead ? dataRdata : exMemQ.aluResult};

    pipeReg #(.payloadT(memWbT)) memWb (
        .clk(clk), .arstN(arstN), .hold(1'b0), .bubble(1'b0),
        .d(memWbD), .q(memWbQ)
    );

    // Writeback observation
    assign wbValid = memWbQ.valid && memWbQ.regWrite;
    assign wbDest  = memWbQ.dest;
    assign wbData  = memWbQ.value;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            haltLatch <= 1'b0;
        end else if (memWbQ.valid && memWbQ.halt) begin
            haltLatch <= 1'b1;
        end
    end

    assign halted = haltLatch || (memWbQ.valid && memWbQ.halt);   // High from HALT in WB on

endmodule

`default_nettype wire

// File: bench/isaModel.svh
// Architectural model of the instruction set for the testbench
// Instruction encoders and the program builder
// Memory image load into the DUT through hierarchical references
// Reference execution that fills the expected writeback queue
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

typedef struct packed {
    logic    checkErr;     // err compared at this writeback
    logic    errVal;
    regAddrT dest;
    wordT    value;
} expectT;

wordT   prog[$];
wordT   modelMem [0:MemWords-1];
wordT   modelRegs [0:(1<<RegAddrWidth)-1];
expectT expected[$];
int     fixedStart;            // First word after the random block

function automatic wordT encR(opcodeT op, regAddrT rd, regAddrT rs, regAddrT rt);
    return {op, rd, rs, rt, 3'b000};
endfunction

function automatic wordT encI(opcodeT op, regAddrT rd, regAddrT rs, logic [5:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic wordT encLbi(regAddrT rd, logic [8:0] imm);
    return {OpLbi, rd, imm};
endfunction

function automatic wordT encJ(logic [11:0] offset);
    return {OpJ, offset};
endfunction

// Random ALU block on r0..r3, then the fixed control and memory block
task automatic buildProgram(int randomOps);
    int      pick;
    regAddrT rd, rs, rt;
    prog.delete();
    for (int r = 0; r < 4; r++) begin
        prog.push_back(encLbi(regAddrT'(r), 9'($urandom)));
    end
    for (int i = 0; i < randomOps; i++) begin
        pick = $urandom_range(5, 0);
        rd   = regAddrT'($urandom_range(3, 0));
        rs   = regAddrT'($urandom_range(3, 0));
        rt   = regAddrT'($urandom_range(3, 0));
        case (pick)
            0:       prog.push_back(encR(OpAdd, rd, rs, rt));
            1:       prog.push_back(encR(OpSub, rd, rs, rt));
            2:       prog.push_back(encR(OpAnd, rd, rs, rt));
            3:       prog.push_back(encR(OpXor, rd, rs, rt));
            4:       prog.push_back(encI(OpAddi, rd, rs, 6'($urandom)));
            default: prog.push_back(encLbi(rd, 9'($urandom)));
        endcase
    end
    fixedStart = prog.size();
    prog.push_back(encLbi(3'd4, 9'd200));           // Data area base
    prog.push_back(encI(OpSt, 3'd1, 3'd4, 6'd0));
    prog.push_back(encI(OpSt, 3'd2, 3'd4, 6'd1));
    prog.push_back(encI(OpLd, 3'd5, 3'd4, 6'd0));
    prog.push_back(encI(OpLd, 3'd6, 3'd4, 6'd1));
    prog.push_back(encLbi(3'd7, 9'd0));
    prog.push_back(encI(OpBeqz, 3'd0, 3'd7, 6'd1)); // Taken
    prog.push_back(encLbi(3'd5, 9'd77));            // Skipped
    prog.push_back(encI(OpBeqz, 3'd0, 3'd4, 6'd1)); // Not taken
    prog.push_back(encI(OpAddi, 3'd6, 3'd6, 6'd5));
    prog.push_back(encJ(12'd1));
    prog.push_back(encLbi(3'd7, 9'd99));            // Jumped over
    prog.push_back(16'hA123);                       // Opcode 10 is unused
    prog.push_back(encLbi(3'd7, 9'd33));
    prog.push_back({OpHalt, 12'h000});
endtask

task automatic loadMemory();
    for (int a = 0; a < MemWords; a++) begin
        if (a < prog.size()) begin
            modelMem[a] = prog[a];
        end else begin
            modelMem[a] = {OpHalt, 4'h0, 8'(a)};      // Stray fetch halts
        end
        DUT.mainMem.mem[a] = modelMem[a];
    end
endtask

function automatic void expectWrite(regAddrT rd, wordT value, logic chk, logic errNow);
    modelRegs[rd] = value;
    expected.push_back('{checkErr: chk, errVal: errNow, dest: rd, value: value});
endfunction

// One instruction per step in program order
task automatic runModel();
    wordT    pc, w, next, addr;
    regAddrT rd, rs, rt;
    logic    illegalSeen, done, chk;
    pc          = '0;
    illegalSeen = 1'b0;
    done        = 1'b0;
    expected.delete();
    foreach (modelRegs[i]) begin
        modelRegs[i] = '0;
    end
    for (int step = 0; step < MemWords && !done; step++) begin
        w    = modelMem[pc[MemAddrWidth-1:0]];
        rd   = w[11:9];
        rs   = w[8:6];
        rt   = w[5:3];
        next = pc + 16'd1;
        chk  = illegalSeen || pc < wordT'(fixedStart);  // Near the illegal word err may lag
        case (w[15:12])
            OpAdd:  expectWrite(rd, modelRegs[rs] + modelRegs[rt], chk, illegalSeen);
            OpSub:  expectWrite(rd, modelRegs[rs] - modelRegs[rt], chk, illegalSeen);
            OpAnd:  expectWrite(rd, modelRegs[rs] & modelRegs[rt], chk, illegalSeen);
            OpXor:  expectWrite(rd, modelRegs[rs] ^ modelRegs[rt], chk, illegalSeen);
            OpAddi: expectWrite(rd, modelRegs[rs] + wordT'($signed(w[5:0])), chk, illegalSeen);
            OpLbi:  expectWrite(rd, wordT'($signed(w[8:0])), chk, illegalSeen);
            OpLd: begin
                addr = modelRegs[rs] + wordT'($signed(w[5:0]));
                expectWrite(rd, modelMem[addr[MemAddrWidth-1:0]], chk, illegalSeen);
            end
            OpSt: begin
                addr = modelRegs[rs] + wordT'($signed(w[5:0]));
                modelMem[addr[MemAddrWidth-1:0]] = modelRegs[rd];
            end
            OpBeqz: begin
                if (modelRegs[rs] == '0) begin
                    next = pc + 16'd1 + wordT'($signed(w[5:0]));
                end
            end
            OpJ:     next = pc + 16'd1 + wordT'($signed(w[11:0]));
            OpHalt:  done = 1'b1;
            default: illegalSeen = 1'b1;             // No-op apart from the flag
        endcase
        pc = next;
    end
endtask

`endif

// File: bench/procTb.sv
// Testbench for the pipelined core
// Clock, reset and program load through the ISA model
// Writeback scoreboard and flag checks as assertions
// Cycle timeout and closing summary
`timescale 1ns/10ps
`default_nettype none

module procTb;
    import cpuPkg::*;

    logic        clk   = 1'b0;
    logic        arstN = 1'b0;
    logic        err, halted, wbValid;
    regAddrT     wbDest;
    wordT        wbData;
    int          errorCount   = 0;
    int          wbChecks     = 0;
    int          cycleCount   = 0;
    int          timeoutLimit = 1000;    // Replaced once the program length is known

    `include "isaModel.svh"

    expectT wbHead;

    proc DUT (
        .clk(clk), .arstN(arstN), .err(err), .halted(halted),
        .wbValid(wbValid), .wbDest(wbDest), .wbData(wbData)
    );

    always #5 clk = ~clk;

    // Writeback scoreboard against the model queue
    always @(posedge clk) begin
        if (arstN && wbValid) begin
            wbChecks++;
            wbExpected: assert (expected.size() != 0) else begin
                errorCount++;
                $display("Unexpected writeback of r%0d = %h after the last expected result",
                         wbDest, wbData);
            end
            if (expected.size() != 0) begin
                wbHead = expected.pop_front();
                wbMatch: assert (wbDest == wbHead.dest && wbData == wbHead.value) else begin
                    errorCount++;
                    $display("ERROR at %0t: writeback r%0d = %h, expected r%0d = %h",
                             $time, wbDest, wbData, wbHead.dest, wbHead.value);
                end
                errAtWb: assert (!wbHead.checkErr || err == wbHead.errVal) else begin
                    errorCount++;
                    $display("ERROR at %0t: err = %b at writeback, expected %b",
                             $time, err, wbHead.errVal);
                end
            end
        end
    end

    // First edge skipped, the async reset may not have acted yet
    resetQuiet: assert property (@(posedge clk)
        (!arstN && cycleCount > 0) |-> (!wbValid && !halted && !err) ##1
                                       (!wbValid && !halted && !err))
        else begin
            errorCount++;
            $display("ERROR at %0t: wbValid, halted or err set around reset", $time);
        end

    errSticky: assert property (@(posedge clk) disable iff (!arstN) err |=> err)
        else begin
            errorCount++;
            $display("ERROR at %0t: err dropped after being set", $time);
        end

    haltedSticky: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
        else begin
            errorCount++;
            $display("ERROR at %0t: halted dropped after being set", $time);
        end

    quietAfterHalt: assert property (@(posedge clk) disable iff (!arstN) halted |-> !wbValid)
        else begin
            errorCount++;
            $display("ERROR at %0t: writeback seen after halt", $time);
        end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            $display("Timeout: the core did not halt within %0d cycles", timeoutLimit);
            $display("Summary: %0d writebacks checked, %0d errors", wbChecks, errorCount + 1);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hb5af_b892));   // Seeds the generator
        buildProgram(20);
        loadMemory();
        runModel();
        timeoutLimit = 6 * prog.size() + 50;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        do begin
            @(posedge clk);
        end while (!halted);
        drainedAtHalt: assert (expected.size() == 0) else begin
            errorCount++;
            $display("Halted with %0d expected writebacks still missing", expected.size());
        end
        repeat (4) @(posedge clk);
        errAtEnd: assert (err) else begin
            errorCount++;
            $display("ERROR at %0t: err = 0 after the illegal instruction", $time);
        end
        $display("Summary: %0d writebacks checked, %0d errors", wbChecks, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+bench
hdl/cpuPkg.sv
hdl/pipeReg.sv
hdl/fetchUnit.sv
hdl/decodeUnit.sv
hdl/executeUnit.sv
hdl/memArbiter.sv
hdl/unifiedMemory.sv
hdl/proc.sv
bench/procTb.sv
